//--- Bender.yml
package:
  name: car_drive

sources:
  - source/car_pkg.sv
  - source/tracker_decode.sv
  - source/drive_table.sv
  - source/pwm_gen.sv
  - source/drive_regs.sv
  - source/car_drive_top.sv
  - target: test
    files:
      - bench/car_drive_tb.sv

//--- bench/car_drive_tb.sv
`timescale 1ns/1ps

module car_drive_tb;

    localparam int period = int'(car_pkg::pwm_period);
    // Four drive tests of at most two PWM periods each, plus register and sensor traffic
    localparam int max_cycles = 12 * period + 2000;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [car_pkg::addr_width-1:0] awaddr = '0;
    logic awvalid = 1'b0;
    logic [31:0] wdata = '0;
    logic [3:0] wstrb = '0;
    logic wvalid = 1'b0;
    logic bready = 1'b0;
    logic [car_pkg::addr_width-1:0] araddr = '0;
    logic arvalid = 1'b0;
    logic rready = 1'b0;
    logic [2:0] sensor = 3'b000;
    logic awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    logic [31:0] rdata;
    logic pwm_left, pwm_right, dir_left, dir_right;

    // Model of the register file indexed by word address
    logic [31:0] reg_model [0:6];
    car_pkg::drive_mode_e exp_mode = car_pkg::back;
    logic [1:0] exp_bresp = car_pkg::resp_okay;
    logic [1:0] exp_rresp = car_pkg::resp_okay;
    logic [31:0] exp_rdata = '0;
    logic dir_armed = 1'b1;
    logic pwm_armed = 1'b0;
    logic low_armed = 1'b0;
    int exp_high [2] = '{0, 0};
    int axi_errors = 0;
    int dir_errors = 0;
    int pwm_errors = 0;
    int cycles = 0;
    logic [2:0] patterns [9] = '{3'b010, 3'b110, 3'b100, 3'b101, 3'b011,
                                3'b001, 3'b111, 3'b000, 3'b101};

    // Periods are measured between rising edges and index 0 is the left wheel
    logic [1:0] pwm_now;
    logic [1:0] pwm_prev = 2'b00;
    logic [1:0] period_done = 2'b00;
    logic [1:0] measured = 2'b00;
    int run_len [2] = '{0, 0};
    int high_len [2] = '{0, 0};
    int last_period [2] = '{0, 0};
    int last_high [2] = '{0, 0};

    car_drive_top i_car_drive_top (.*);

    always #20 clk = ~clk;

    assign pwm_now = {pwm_right, pwm_left};

    always @(negedge clk) begin
        for (int s = 0; s < 2; s++) begin
            period_done[s] = pwm_now[s] && !pwm_prev[s];
            if (period_done[s]) begin
                last_period[s] = run_len[s];
                last_high[s] = high_len[s];
                run_len[s] = 0;
                high_len[s] = 0;
            end
            run_len[s] = run_len[s] + 1;
            high_len[s] = high_len[s] + (pwm_now[s] ? 1 : 0);
            pwm_prev[s] = pwm_now[s];
        end
    end

    always @(posedge clk) begin
        measured = measured | (pwm_armed ? period_done : 2'b00);
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic car_pkg::drive_mode_e decode_sensor(input logic [2:0] s,
                                                          input car_pkg::drive_mode_e last);
        case (s)
            3'b010, 3'b111: return car_pkg::go_straight;
            3'b110: return car_pkg::turn_left;
            3'b100: return car_pkg::sharp_left;
            3'b011: return car_pkg::turn_right;
            3'b001: return car_pkg::sharp_right;
            3'b101: return last;
            default: return car_pkg::back;
        endcase
    endfunction

    // Only the inner wheel of a sharp turn reverses while back mode reverses both
    function automatic logic wheel_forward(input logic right_side);
        logic inner_sharp;
        inner_sharp = right_side ? (exp_mode == car_pkg::sharp_right)
                                 : (exp_mode == car_pkg::sharp_left);
        if (!reg_model[0][0]) begin
            return 1'b1;
        end
        return !(inner_sharp || exp_mode == car_pkg::back);
    endfunction

    function automatic int wheel_duty(input logic right_side);
        logic inner;
        inner = right_side ? (exp_mode inside {car_pkg::turn_right, car_pkg::sharp_right})
                           : (exp_mode inside {car_pkg::turn_left, car_pkg::sharp_left});
        if (!reg_model[0][0]) begin
            return 0;
        end
        case (exp_mode)
            car_pkg::go_straight: return int'(reg_model[1]);
            car_pkg::turn_left, car_pkg::turn_right:
                return int'(inner ? reg_model[2] : reg_model[3]);
            car_pkg::sharp_left, car_pkg::sharp_right:
                return int'(inner ? reg_model[4] : reg_model[5]);
            default: return int'(reg_model[6]);
        endcase
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_value,
                                                 input logic [31:0] data,
                                                 input logic [3:0] strb,
                                                 input logic [31:0] mask);
        logic [31:0] merged;
        merged = old_value;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged & mask;
    endfunction

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic writable;
        int delay;
        writable = (addr[1:0] == 2'b00) && (addr[4:2] != 3'd7);
        delay = $urandom_range(3, 0);
        exp_bresp = writable ? car_pkg::resp_okay : car_pkg::resp_slverr;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do @(negedge clk); while (!awready);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (delay) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (writable) begin
            reg_model[addr[4:2]] = apply_strobe(reg_model[addr[4:2]], data, strb,
                                                (addr[4:2] == 3'd0) ? 32'h1 : 32'h3FF);
        end
    endtask

    task automatic axi_read(input logic [4:0] addr);
        int delay;
        delay = $urandom_range(3, 0);
        exp_rresp = (addr[1:0] == 2'b00) ? car_pkg::resp_okay : car_pkg::resp_slverr;
        if (addr[1:0] != 2'b00) begin
            exp_rdata = '0;
        end else if (addr[4:2] == 3'd7) begin
            exp_rdata = {29'd0, exp_mode};
        end else begin
            exp_rdata = reg_model[addr[4:2]];
        end
        araddr = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (delay) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic set_enable(input logic value);
        dir_armed = 1'b0;
        axi_write(5'h00, {31'd0, value}, 4'hF);
        repeat (2) @(negedge clk);
        dir_armed = 1'b1;
    endtask

    task automatic apply_sensor(input logic [2:0] pattern);
        sensor = pattern;
        exp_mode = decode_sensor(pattern, exp_mode);
        repeat (6) @(negedge clk);
    endtask

    task automatic check_pwm_mode(input logic [2:0] pattern);
        pwm_armed = 1'b0;
        apply_sensor(pattern);
        exp_high[0] = period * wheel_duty(1'b0) / 1024;
        exp_high[1] = period * wheel_duty(1'b1) / 1024;
        // The new duty is latched at the next period start
        repeat (period + 4) @(negedge clk);
        measured = 2'b00;
        pwm_armed = 1'b1;
        while (measured != 2'b11) @(negedge clk);
        pwm_armed = 1'b0;
    endtask

    ready_pair_check: assert property (@(posedge clk) disable iff (reset)
        wready == awready
    ) else begin
        axi_errors++;
        $display("[FAIL] %0t: wready %b and awready %b not pulsed together", $time,
                 $sampled(wready), $sampled(awready));
    end

    write_resp_check: assert property (@(posedge clk) disable iff (reset)
        bvalid && bready |-> bresp == exp_bresp
    ) else begin
        axi_errors++;
        $display("[FAIL] %0t: bresp %0d, expected %0d", $time, $sampled(bresp), exp_bresp);
    end

    read_resp_check: assert property (@(posedge clk) disable iff (reset)
        rvalid && rready |-> rdata == exp_rdata && rresp == exp_rresp
    ) else begin
        axi_errors++;
        $display("[FAIL] %0t: rdata %0h rresp %0d, expected %0h and %0d", $time,
                 $sampled(rdata), $sampled(rresp), exp_rdata, exp_rresp);
    end

    dir_check: assert property (@(posedge clk) disable iff (reset)
        dir_armed && sensor == $past(sensor, 1) && sensor == $past(sensor, 2)
            && sensor == $past(sensor, 3) && sensor == $past(sensor, 4)
        |-> dir_left == wheel_forward(1'b0) && dir_right == wheel_forward(1'b1)
    ) else begin
        dir_errors++;
        $display("[FAIL] %0t: directions %b%b wrong for mode %s", $time,
                 $sampled(dir_left), $sampled(dir_right), exp_mode.name());
    end

    left_period_check: assert property (@(posedge clk) disable iff (reset)
        pwm_armed && period_done[0] |-> last_period[0] == period && last_high[0] == exp_high[0]
    ) else begin
        pwm_errors++;
        $display("[FAIL] %0t: left period %0d high %0d, expected %0d high %0d", $time,
                 last_period[0], last_high[0], period, exp_high[0]);
    end

    right_period_check: assert property (@(posedge clk) disable iff (reset)
        pwm_armed && period_done[1] |-> last_period[1] == period && last_high[1] == exp_high[1]
    ) else begin
        pwm_errors++;
        $display("[FAIL] %0t: right period %0d high %0d, expected %0d high %0d", $time,
                 last_period[1], last_high[1], period, exp_high[1]);
    end

    pwm_low_check: assert property (@(posedge clk) disable iff (reset)
        low_armed |-> !pwm_left && !pwm_right
    ) else begin
        pwm_errors++;
        $display("[FAIL] %0t: PWM output high while the drive is disabled", $time);
    end

    initial begin
        void'($urandom(37));
        reg_model[0] = 32'd0;
        reg_model[1] = 32'(car_pkg::straight_speed_reset);
        reg_model[2] = 32'(car_pkg::turn_in_reset);
        reg_model[3] = 32'(car_pkg::turn_out_reset);
        reg_model[4] = 32'(car_pkg::sharp_in_reset);
        reg_model[5] = 32'(car_pkg::sharp_out_reset);
        reg_model[6] = 32'(car_pkg::back_speed_reset);
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        for (int i = 1; i <= 6; i++) begin
            repeat (3) begin
                axi_write(5'(4 * i), $urandom(), 4'($urandom_range(15, 0)));
                axi_read(5'(4 * i));
            end
        end
        // Status is read-only and unaligned words are outside the map
        axi_write(5'h1C, $urandom(), 4'hF);
        axi_read(5'h1C);
        axi_write(5'h0E, $urandom(), 4'hF);
        axi_read(5'h0C);
        axi_read(5'h05);
        axi_read(5'h1F);

        for (int i = 1; i <= 6; i++) begin
            axi_write(5'(4 * i), $urandom_range(1023, 64), 4'hF);
        end
        set_enable(1'b1);
        axi_read(5'h00);
        foreach (patterns[k]) begin
            apply_sensor(patterns[k]);
            axi_read(5'h1C);
        end

        check_pwm_mode(3'b110);
        check_pwm_mode(3'b011);
        check_pwm_mode(3'b001);

        set_enable(1'b0);
        repeat (period + 2) @(negedge clk);
        low_armed = 1'b1;
        repeat (period) @(negedge clk);
        low_armed = 1'b0;

        $display("Errors: axi %0d, direction %0d, pwm %0d", axi_errors, dir_errors, pwm_errors);
        if (axi_errors + dir_errors + pwm_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
source/car_pkg.sv
source/tracker_decode.sv
source/drive_table.sv
source/pwm_gen.sv
source/drive_regs.sv
source/car_drive_top.sv
bench/car_drive_tb.sv

//--- source/car_drive_top.sv
`timescale 1ns/1ps

module car_drive_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [car_pkg::addr_width-1:0]   awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [31:0]                      wdata,
    input  logic [3:0]                       wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [car_pkg::addr_width-1:0]   araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [31:0]                      rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    input  logic [2:0]                       sensor,
    output logic                             pwm_left,
    output logic                             pwm_right,
    output logic                             dir_left,
    output logic                             dir_right
);

    car_pkg::drive_mode_e mode;
    logic enable;
    logic [car_pkg::duty_width-1:0] speed_straight;
    logic [car_pkg::duty_width-1:0] speed_turn_in;
    logic [car_pkg::duty_width-1:0] speed_turn_out;
    logic [car_pkg::duty_width-1:0] speed_sharp_in;
    logic [car_pkg::duty_width-1:0] speed_sharp_out;
    logic [car_pkg::duty_width-1:0] speed_back;
    logic [car_pkg::duty_width-1:0] duty_left;
    logic [car_pkg::duty_width-1:0] duty_right;

    drive_regs i_drive_regs (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .mode, .enable,
        .speed_straight, .speed_turn_in, .speed_turn_out,
        .speed_sharp_in, .speed_sharp_out, .speed_back
    );

    tracker_decode i_tracker_decode (.clk, .reset, .sensor, .mode);

    drive_table i_drive_table (
        .clk, .reset, .mode, .enable,
        .speed_straight, .speed_turn_in, .speed_turn_out,
        .speed_sharp_in, .speed_sharp_out, .speed_back,
        .duty_left, .duty_right, .dir_left, .dir_right
    );

    pwm_gen i_pwm_left (.clk, .reset, .duty(duty_left), .pwm(pwm_left));

    pwm_gen i_pwm_right (.clk, .reset, .duty(duty_right), .pwm(pwm_right));

endmodule

//--- source/car_pkg.sv
package car_pkg;

    // Widths
    localparam int duty_width = 10;
    localparam int addr_width = 5;
    localparam int cnt_width = 12;

    // One PWM period in clock cycles, 25 kHz at a 100 MHz clock
    localparam logic [cnt_width-1:0] pwm_period = 12'd4000;

    // Speed values loaded into the registers at reset, 1023 is full speed
    localparam logic [duty_width-1:0] straight_speed_reset = 10'd1023;
    localparam logic [duty_width-1:0] turn_in_reset = 10'd538;
    localparam logic [duty_width-1:0] turn_out_reset = 10'd1023;
    localparam logic [duty_width-1:0] sharp_in_reset = 10'd512;
    localparam logic [duty_width-1:0] sharp_out_reset = 10'd1023;
    localparam logic [duty_width-1:0] back_speed_reset = 10'd768;

    // AXI response codes
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Steering modes decoded from the three line sensors
    typedef enum logic [2:0] {
        go_straight = 3'd0,
        turn_left   = 3'd1,
        turn_right  = 3'd2,
        sharp_left  = 3'd3,
        sharp_right = 3'd4,
        back        = 3'd5
    } drive_mode_e;

    // Byte addresses of the register map, one 32-bit word each
    typedef enum logic [addr_width-1:0] {
        ctrl            = 5'h00,
        speed_straight  = 5'h04,
        speed_turn_in   = 5'h08,
        speed_turn_out  = 5'h0C,
        speed_sharp_in  = 5'h10,
        speed_sharp_out = 5'h14,
        speed_back      = 5'h18,
        status          = 5'h1C
    } reg_addr_e;

endpackage

//--- source/drive_regs.sv
`timescale 1ns/1ps

module drive_regs (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [car_pkg::addr_width-1:0]   awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [31:0]                      wdata,
    input  logic [3:0]                       wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [car_pkg::addr_width-1:0]   araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [31:0]                      rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    input  car_pkg::drive_mode_e             mode,
    output logic                             enable,
    output logic [car_pkg::duty_width-1:0]   speed_straight,
    output logic [car_pkg::duty_width-1:0]   speed_turn_in,
    output logic [car_pkg::duty_width-1:0]   speed_turn_out,
    output logic [car_pkg::duty_width-1:0]   speed_sharp_in,
    output logic [car_pkg::duty_width-1:0]   speed_sharp_out,
    output logic [car_pkg::duty_width-1:0]   speed_back
);

    logic write_start;
    logic write_fire;
    logic read_start;
    logic read_fire;
    logic [31:0] read_data;
    logic read_err;

    // Speeds span two bytes of the word
    function automatic logic [car_pkg::duty_width-1:0] merge_speed(
        input logic [car_pkg::duty_width-1:0] old_value,
        input logic [31:0] data,
        input logic [3:0] strb
    );
        logic [car_pkg::duty_width-1:0] result;
        result = old_value;
        if (strb[0]) begin
            result[7:0] = data[7:0];
        end
        if (strb[1]) begin
            result[9:8] = data[9:8];
        end
        return result;
    endfunction

    // Ready goes high for one cycle once both write channels are valid
    assign write_start = awvalid && wvalid && !bvalid && !awready;
    assign write_fire = awready && awvalid && wvalid;
    assign read_start = arvalid && !rvalid && !arready;
    assign read_fire = arready && arvalid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= car_pkg::resp_okay;
            enable <= 1'b0;
            speed_straight <= car_pkg::straight_speed_reset;
            speed_turn_in <= car_pkg::turn_in_reset;
            speed_turn_out <= car_pkg::turn_out_reset;
            speed_sharp_in <= car_pkg::sharp_in_reset;
            speed_sharp_out <= car_pkg::sharp_out_reset;
            speed_back <= car_pkg::back_speed_reset;
        end else begin
            awready <= write_start;
            wready <= write_start;
            if (write_fire) begin
                bvalid <= 1'b1;
                bresp <= car_pkg::resp_okay;
                case (car_pkg::reg_addr_e'(awaddr))
                    car_pkg::ctrl: begin
                        if (wstrb[0]) begin
                            enable <= wdata[0];
                        end
                    end
                    car_pkg::speed_straight:
                        speed_straight <= merge_speed(speed_straight, wdata, wstrb);
                    car_pkg::speed_turn_in:
                        speed_turn_in <= merge_speed(speed_turn_in, wdata, wstrb);
                    car_pkg::speed_turn_out:
                        speed_turn_out <= merge_speed(speed_turn_out, wdata, wstrb);
                    car_pkg::speed_sharp_in:
                        speed_sharp_in <= merge_speed(speed_sharp_in, wdata, wstrb);
                    car_pkg::speed_sharp_out:
                        speed_sharp_out <= merge_speed(speed_sharp_out, wdata, wstrb);
                    car_pkg::speed_back:
                        speed_back <= merge_speed(speed_back, wdata, wstrb);
                    // Status is read-only, unmapped words do not exist
                    default: bresp <= car_pkg::resp_slverr;
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        read_err = 1'b0;
        case (car_pkg::reg_addr_e'(araddr))
            car_pkg::ctrl: read_data = {31'd0, enable};
            car_pkg::speed_straight: read_data = {22'd0, speed_straight};
            car_pkg::speed_turn_in: read_data = {22'd0, speed_turn_in};
            car_pkg::speed_turn_out: read_data = {22'd0, speed_turn_out};
            car_pkg::speed_sharp_in: read_data = {22'd0, speed_sharp_in};
            car_pkg::speed_sharp_out: read_data = {22'd0, speed_sharp_out};
            car_pkg::speed_back: read_data = {22'd0, speed_back};
            car_pkg::status: read_data = {29'd0, mode};
            default: begin
                read_data = 32'd0;
                read_err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rresp <= car_pkg::resp_okay;
        end else begin
            arready <= read_start;
            if (read_fire) begin
                rvalid <= 1'b1;
                rresp <= read_err ? car_pkg::resp_slverr : car_pkg::resp_okay;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_fire) begin
            rdata <= read_data;
        end
    end

    bvalid_held: assert property (
        @(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("drive_regs: write response dropped before bready");

    rvalid_held: assert property (
        @(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata)
    ) else $error("drive_regs: read response dropped before rready");

endmodule

//--- source/drive_table.sv
`timescale 1ns/1ps

module drive_table (
    input  logic                             clk,
    input  logic                             reset,
    input  car_pkg::drive_mode_e             mode,
    input  logic                             enable,
    input  logic [car_pkg::duty_width-1:0]   speed_straight,
    input  logic [car_pkg::duty_width-1:0]   speed_turn_in,
    input  logic [car_pkg::duty_width-1:0]   speed_turn_out,
    input  logic [car_pkg::duty_width-1:0]   speed_sharp_in,
    input  logic [car_pkg::duty_width-1:0]   speed_sharp_out,
    input  logic [car_pkg::duty_width-1:0]   speed_back,
    output logic [car_pkg::duty_width-1:0]   duty_left,
    output logic [car_pkg::duty_width-1:0]   duty_right,
    output logic                             dir_left,
    output logic                             dir_right
);

    logic [car_pkg::duty_width-1:0] speed_left;
    logic [car_pkg::duty_width-1:0] speed_right;
    logic fwd_left;
    logic fwd_right;

    // The inner wheel of a turn is the one on the side of the turn
    always_comb begin
        fwd_left = 1'b1;
        fwd_right = 1'b1;
        case (mode)
            car_pkg::go_straight: begin
                speed_left = speed_straight;
                speed_right = speed_straight;
            end
            car_pkg::turn_left: begin
                speed_left = speed_turn_in;
                speed_right = speed_turn_out;
            end
            car_pkg::turn_right: begin
                speed_left = speed_turn_out;
                speed_right = speed_turn_in;
            end
            car_pkg::sharp_left: begin
                speed_left = speed_sharp_in;
                speed_right = speed_sharp_out;
                fwd_left = 1'b0;
            end
            car_pkg::sharp_right: begin
                speed_left = speed_sharp_out;
                speed_right = speed_sharp_in;
                fwd_right = 1'b0;
            end
            default: begin
                speed_left = speed_back;
                speed_right = speed_back;
                fwd_left = 1'b0;
                fwd_right = 1'b0;
            end
        endcase
    end

    // A disabled car coasts with both bridges set forward
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty_left <= '0;
            duty_right <= '0;
            dir_left <= 1'b1;
            dir_right <= 1'b1;
        end else begin
            duty_left <= enable ? speed_left : '0;
            duty_right <= enable ? speed_right : '0;
            dir_left <= enable ? fwd_left : 1'b1;
            dir_right <= enable ? fwd_right : 1'b1;
        end
    end

    both_reverse_only_back: assert property (
        @(posedge clk) disable iff (reset)
        !dir_left && !dir_right |-> $past(mode) == car_pkg::back
    ) else $error("drive_table: both wheels in reverse outside back mode");

endmodule

//--- source/pwm_gen.sv
`timescale 1ns/1ps

module pwm_gen (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [car_pkg::duty_width-1:0] duty,
    output logic                           pwm
);

    logic [car_pkg::cnt_width-1:0] count;
    logic [car_pkg::cnt_width-1:0] high_len;
    logic [car_pkg::cnt_width+car_pkg::duty_width-1:0] product;
    logic [car_pkg::cnt_width-1:0] new_len;
    logic period_end;

    // High length is period * duty / 1024, truncated
    assign product = {{car_pkg::cnt_width{1'b0}}, duty}
                   * {{car_pkg::duty_width{1'b0}}, car_pkg::pwm_period};
    assign new_len = product[car_pkg::cnt_width+car_pkg::duty_width-1:car_pkg::duty_width];
    assign period_end = (count == car_pkg::pwm_period - 1'b1);

    // Duty is taken only when the count wraps, so a period is never cut short
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            high_len <= '0;
            pwm <= 1'b0;
        end else if (period_end) begin
            count <= '0;
            high_len <= new_len;
            pwm <= (new_len != '0);
        end else begin
            count <= count + 1'b1;
            pwm <= (count + 1'b1) < high_len;
        end
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        count < car_pkg::pwm_period
    ) else $error("pwm_gen: counter reached the period");

endmodule

//--- source/tracker_decode.sv
`timescale 1ns/1ps

module tracker_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [2:0]           sensor,
    output car_pkg::drive_mode_e mode
);

    logic [2:0] sync_1;
    logic [2:0] sync_2;
    car_pkg::drive_mode_e next_mode;

    // The sensor bits come straight from the board, so two flops first
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= 3'b000;
            sync_2 <= 3'b000;
        end else begin
            sync_1 <= sensor;
            sync_2 <= sync_1;
        end
    end

    // Bit 2 is the left sensor, bit 0 the right one
    always_comb begin
        case (sync_2)
            3'b010,
            3'b111: next_mode = car_pkg::go_straight;
            3'b110: next_mode = car_pkg::turn_left;
            3'b100: next_mode = car_pkg::sharp_left;
            3'b011: next_mode = car_pkg::turn_right;
            3'b001: next_mode = car_pkg::sharp_right;
            3'b000: next_mode = car_pkg::back;
            // Left and right without middle is ambiguous so the course is held
            default: next_mode = mode;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= car_pkg::back;
        end else begin
            mode <= next_mode;
        end
    end

    mode_legal: assert property (
        @(posedge clk) disable iff (reset)
        mode inside {car_pkg::go_straight, car_pkg::turn_left, car_pkg::turn_right,
                     car_pkg::sharp_left, car_pkg::sharp_right, car_pkg::back}
    ) else $error("tracker_decode: illegal mode %0d", mode);

endmodule
